/* hdl/snn_consts.svh */
// network sizes and field widths are fixed here; the command word layout assumes they stay consistent
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// one neuron per network input
`define SNN_NUM_INP 4

// signed charge applied to one input in one timestep
`define SNN_CHARGE_WIDTH 8

// periodic entries repeat every 1 to SNN_MAX_PERIOD timesteps
`define SNN_MAX_PERIOD 15
`define SNN_PERIOD_WIDTH 4

`define SNN_IDX_WIDTH 2
`define SNN_RUN_WIDTH 8

// membrane potential is signed and wider than a charge
`define SNN_POT_WIDTH 12
`define SNN_THRESHOLD 64

`define SNN_OPC_WIDTH 3

// opcode + index + charge + period
`define SNN_SRC_WIDTH 17

`endif

/* hdl/net_pkg.sv */
// network data types sized from snn_consts.svh; a period value of 0 marks an unused periodic entry
`default_nettype none

`include "snn_consts.svh"

package net_pkg;

    // charge delivered to one input for one timestep
    typedef logic signed [`SNN_CHARGE_WIDTH-1:0] charge_t;

    typedef logic signed [`SNN_POT_WIDTH-1:0] pot_t;

    typedef logic [`SNN_IDX_WIDTH-1:0] inp_idx_t;

    // zero disables the periodic entry
    typedef logic [$clog2(`SNN_MAX_PERIOD+1)-1:0] period_t;

    // bit i belongs to neuron i
    typedef logic [`SNN_NUM_INP-1:0] spike_vec_t;

endpackage

`default_nettype wire

/* hdl/src_pkg.sv */
// command word layout for the network source; opcodes above SPK_PRDC are not defined and act as NOP
`default_nettype none

`include "snn_consts.svh"

package src_pkg;
    import net_pkg::*;

    typedef enum logic [`SNN_OPC_WIDTH-1:0] {
        NOP      = 0,
        RUN      = 1,
        SPK      = 2,
        CLR      = 3,
        SPK_PRDC = 4
    } opcode_t;

    localparam int RUN_PAD_WIDTH = `SNN_SRC_WIDTH - `SNN_OPC_WIDTH - `SNN_RUN_WIDTH;

    // RUN carries a timestep count right below the opcode
    typedef struct packed {
        opcode_t                   opc;
        logic [`SNN_RUN_WIDTH-1:0] len;
        logic [RUN_PAD_WIDTH-1:0]  pad;
    } run_view_t;

    // SPK and SPK_PRDC address one input; the period is ignored for SPK
    typedef struct packed {
        opcode_t                      opc;
        inp_idx_t                     idx;
        charge_t                      charge;
        logic [`SNN_PERIOD_WIDTH-1:0] period;
    } spk_view_t;

    // both views share the opcode field at the top of the word
    typedef union packed {
        run_view_t run_view;
        spk_view_t spk_view;
    } src_cmd_u;

endpackage

`default_nettype wire

/* hdl/network_source.sv */
// commands are taken only while src_ready is high; a RUN accepted with one timestep still pending adds to it
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module network_source
    import net_pkg::*;
    import src_pkg::*;
(
    input  logic       clk,
    input  logic       arstn,
    input  logic       src_valid,
    output logic       src_ready,
    input  src_cmd_u   src,
    output logic       net_valid,
    input  logic       net_ready,
    output logic       net_clr,
    output charge_t    net_inp [`SNN_NUM_INP],
    output logic       tbl_wr,
    output logic       tbl_clr,
    output inp_idx_t   tbl_idx,
    output charge_t    tbl_charge,
    output period_t    tbl_period,
    output logic       step,
    input  spike_vec_t due_mask,
    input  charge_t    due_charge [`SNN_NUM_INP]
);
    opcode_t                 op;
    logic                    accept;
    logic                    spk_wr;
    logic                    carry;
    logic [`SNN_RUN_WIDTH:0] run_len;
    // one bit wider than the length field so a pending timestep can be added
    logic [`SNN_RUN_WIDTH:0] run_cnt;

    assign accept = src_valid && src_ready;

    // invalid opcodes fall through every compare below and act as NOP
    assign op = accept ? src.run_view.opc : NOP;

    assign src_ready = (run_cnt[`SNN_RUN_WIDTH:1] == '0);
    assign net_valid = (run_cnt != '0);
    assign step      = net_valid && net_ready;

    // a run length of zero still runs one timestep
    assign run_len = (src.run_view.len == '0) ? {{`SNN_RUN_WIDTH{1'b0}}, 1'b1}
                                              : {1'b0, src.run_view.len};

    // the last timestep of the previous run has not gone out yet
    assign carry = net_valid && !step;

    assign spk_wr = (op == SPK) || (op == SPK_PRDC);

    // periodic table writes come straight from the accepted command
    assign tbl_wr     = (op == SPK_PRDC);
    assign tbl_clr    = (op == CLR);
    assign tbl_idx    = src.spk_view.idx;
    assign tbl_charge = src.spk_view.charge;
    assign tbl_period = src.spk_view.period;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            run_cnt <= '0;
        end else if (op == RUN) begin
            run_cnt <= run_len + {{`SNN_RUN_WIDTH{1'b0}}, carry};
        end else if (step) begin
            run_cnt <= run_cnt - 1'b1;
        end
    end

    // input charges for the next timestep
    // a fresh spike wins over a due periodic charge, and anything else drops to zero
    // once a timestep has been taken by the layer
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            net_clr <= 1'b0;
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                net_inp[i] <= '0;
            end
        end else begin
            net_clr <= (op == CLR);
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                if (op == CLR) begin
                    net_inp[i] <= '0;
                end else if (spk_wr && src.spk_view.idx == inp_idx_t'(i)) begin
                    net_inp[i] <= src.spk_view.charge;
                end else if (step) begin
                    net_inp[i] <= due_mask[i] ? due_charge[i] : charge_t'(0);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/periodic_table.sv */
// due flags are combinational from the phase counters and refer to the timestep after the current step
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module periodic_table
    import net_pkg::*;
(
    input  logic       clk,
    input  logic       arstn,
    input  logic       tbl_wr,
    input  logic       tbl_clr,
    input  inp_idx_t   tbl_idx,
    input  charge_t    tbl_charge,
    input  period_t    tbl_period,
    input  logic       step,
    output spike_vec_t due_mask,
    output charge_t    due_charge [`SNN_NUM_INP]
);
    charge_t prd_charge [`SNN_NUM_INP];
    period_t prd_period [`SNN_NUM_INP];
    // counts transferred timesteps since the write, modulo the period
    period_t phase      [`SNN_NUM_INP];

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                prd_charge[i] <= '0;
                prd_period[i] <= '0;
                phase[i]      <= '0;
            end
        end else if (tbl_clr) begin
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                prd_charge[i] <= '0;
                prd_period[i] <= '0;
                phase[i]      <= '0;
            end
        end else begin
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                if (tbl_wr && tbl_idx == inp_idx_t'(i)) begin
                    prd_charge[i] <= tbl_charge;
                    prd_period[i] <= tbl_period;
                    phase[i]      <= '0;
                end else if (step && prd_period[i] != '0) begin
                    phase[i] <= due_mask[i] ? period_t'(0) : period_t'(phase[i] + 1'b1);
                end
            end
        end
    end

    // due when this step completes a full period, so the charge lands on the following one
    always_comb begin
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            due_mask[i]   = (prd_period[i] != '0) &&
                            (phase[i] == period_t'(prd_period[i] - 1'b1));
            due_charge[i] = prd_charge[i];
        end
    end

endmodule

`default_nettype wire

/* hdl/lif_layer.sv */
// integrate-and-fire without leak or refractory time; a clear in the same cycle as a timestep restarts from zero
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module lif_layer
    import net_pkg::*;
(
    input  logic       clk,
    input  logic       arstn,
    input  logic       net_valid,
    output logic       net_ready,
    input  charge_t    net_inp [`SNN_NUM_INP],
    input  logic       net_clr,
    output logic       out_valid,
    input  logic       out_ready,
    output spike_vec_t out_spikes
);
    localparam int POT_MIN = -(2 ** (`SNN_POT_WIDTH - 1));

    pot_t                           pot     [`SNN_NUM_INP];
    pot_t                           pot_nxt [`SNN_NUM_INP];
    logic signed [`SNN_POT_WIDTH:0] sum     [`SNN_NUM_INP];
    spike_vec_t                     fire;
    logic                           xfer;

    // stall the source only while a result is waiting on the host
    assign net_ready = !out_valid || out_ready;
    assign xfer      = net_valid && net_ready;

    always_comb begin
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            if (net_clr) begin
                sum[i] = net_inp[i];
            end else begin
                sum[i] = pot[i] + net_inp[i];
            end
            fire[i] = (sum[i] >= `SNN_THRESHOLD);
            // the upper limit is never reached since the neuron fires long before it
            if (fire[i]) begin
                pot_nxt[i] = '0;
            end else if (sum[i] < POT_MIN) begin
                pot_nxt[i] = pot_t'(POT_MIN);
            end else begin
                pot_nxt[i] = pot_t'(sum[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                pot[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                if (xfer) begin
                    pot[i] <= pot_nxt[i];
                end else if (net_clr) begin
                    pot[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            out_valid <= 1'b0;
        end else if (xfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            out_spikes <= fire;
        end
    end

endmodule

`default_nettype wire

/* hdl/snn_core.sv */
// one layer with one neuron per input; out_spikes is only meaningful while out_valid is high
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module snn_core
    import net_pkg::*;
    import src_pkg::*;
(
    input  logic       clk,
    input  logic       arstn,
    input  logic       src_valid,
    output logic       src_ready,
    input  src_cmd_u   src,
    output logic       out_valid,
    input  logic       out_ready,
    output spike_vec_t out_spikes
);
    logic       net_valid;
    logic       net_ready;
    logic       net_clr;
    charge_t    net_inp    [`SNN_NUM_INP];
    logic       tbl_wr;
    logic       tbl_clr;
    inp_idx_t   tbl_idx;
    charge_t    tbl_charge;
    period_t    tbl_period;
    logic       step;
    spike_vec_t due_mask;
    charge_t    due_charge [`SNN_NUM_INP];

    network_source i_network_source (
        .clk        (clk),
        .arstn      (arstn),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src        (src),
        .net_valid  (net_valid),
        .net_ready  (net_ready),
        .net_clr    (net_clr),
        .net_inp    (net_inp),
        .tbl_wr     (tbl_wr),
        .tbl_clr    (tbl_clr),
        .tbl_idx    (tbl_idx),
        .tbl_charge (tbl_charge),
        .tbl_period (tbl_period),
        .step       (step),
        .due_mask   (due_mask),
        .due_charge (due_charge)
    );

    periodic_table i_periodic_table (
        .clk        (clk),
        .arstn      (arstn),
        .tbl_wr     (tbl_wr),
        .tbl_clr    (tbl_clr),
        .tbl_idx    (tbl_idx),
        .tbl_charge (tbl_charge),
        .tbl_period (tbl_period),
        .step       (step),
        .due_mask   (due_mask),
        .due_charge (due_charge)
    );

    lif_layer i_lif_layer (
        .clk        (clk),
        .arstn      (arstn),
        .net_valid  (net_valid),
        .net_ready  (net_ready),
        .net_inp    (net_inp),
        .net_clr    (net_clr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_spikes (out_spikes)
    );

endmodule

`default_nettype wire

/* tb/snn_core_sva.sv */
// bound into snn_core; the stall checks hold only while the host leaves commands alone during a run
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module snn_core_sva
    import net_pkg::*;
    import src_pkg::*;
(
    input logic     clk,
    input logic     arstn,
    input logic     src_valid,
    input logic     src_ready,
    input src_cmd_u src,
    input logic     net_valid,
    input logic     net_ready,
    input logic     net_clr,
    input charge_t  net_inp [`SNN_NUM_INP],
    input logic     out_valid
);
    logic [`SNN_NUM_INP*`SNN_CHARGE_WIDTH-1:0] inp_flat;

    // number of failed assertions so far
    int sva_errors;

    always_comb begin
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            inp_flat[i*`SNN_CHARGE_WIDTH +: `SNN_CHARGE_WIDTH] = net_inp[i];
        end
    end

    a_src_stable: assert property (@(posedge clk) disable iff (!arstn)
        src_valid && !src_ready |=> $stable(src))
        else begin
            $error("command word changed while waiting for src_ready");
            sva_errors++;
        end

    a_inp_stable: assert property (@(posedge clk) disable iff (!arstn)
        net_valid && !net_ready |=> $stable(inp_flat))
        else begin
            $error("input charges changed while the layer stalled");
            sva_errors++;
        end

    a_clr_pulse: assert property (@(posedge clk) disable iff (!arstn)
        net_clr |=> !net_clr)
        else begin
            $error("net_clr stayed high for more than one cycle");
            sva_errors++;
        end

    a_out_after_reset: assert property (@(posedge clk)
        $rose(arstn) |-> !out_valid && !net_valid && !net_clr)
        else begin
            $error("outputs not idle right after reset");
            sva_errors++;
        end

endmodule

bind snn_core snn_core_sva i_snn_core_sva (.*);

`default_nettype wire

/* tb/snn_core_tb.sv */
// commands are sent only once the previous run has fully drained; expected vectors come from a timestep-level model
`timescale 1ns/100ps
`default_nettype none

`include "snn_consts.svh"

module snn_core_tb
    import net_pkg::*;
    import src_pkg::*;
();
    localparam int POT_MIN = -(1 << (`SNN_POT_WIDTH - 1));

    logic       clk;
    logic       arstn;
    logic       src_valid;
    logic       src_ready;
    src_cmd_u   src;
    logic       out_valid;
    logic       out_ready;
    spike_vec_t out_spikes;

    // command table, one entry per row in each queue
    string       row_name [$];
    src_cmd_u    row_cmd  [$];
    logic [79:0] row_exp  [$];

    // reference model state, one entry per neuron
    int pot  [`SNN_NUM_INP];
    int pend [`SNN_NUM_INP];
    int pchg [`SNN_NUM_INP];
    int pper [`SNN_NUM_INP];
    int pph  [`SNN_NUM_INP];

    logic [31:0] lfsr;
    int          errors;
    int          failed;
    int          wd_cycles;

    snn_core i_snn_core (
        .clk        (clk),
        .arstn      (arstn),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src        (src),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_spikes (out_spikes)
    );

    always #20 clk = ~clk;

    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic src_cmd_u make_run(input int len);
        src_cmd_u c;
        c = '0;
        c.run_view.opc = RUN;
        c.run_view.len = len[`SNN_RUN_WIDTH-1:0];
        return c;
    endfunction

    function automatic src_cmd_u make_spk(input opcode_t op, input int idx, input int chg,
                                          input int per);
        src_cmd_u c;
        c.spk_view.opc    = op;
        c.spk_view.idx    = inp_idx_t'(idx);
        c.spk_view.charge = charge_t'(chg);
        c.spk_view.period = per[`SNN_PERIOD_WIDTH-1:0];
        return c;
    endfunction

    task automatic add_row(input string name, input src_cmd_u cmd, input logic [79:0] exp);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_exp.push_back(exp);
    endtask

    function automatic void model_cmd(input src_cmd_u c);
        int i;
        i = int'(c.spk_view.idx);
        case (c.run_view.opc)
            SPK: pend[i] = c.spk_view.charge;
            SPK_PRDC: begin
                pend[i] = c.spk_view.charge;
                pchg[i] = c.spk_view.charge;
                pper[i] = int'(c.spk_view.period);
                pph[i]  = 0;
            end
            CLR: begin
                for (int k = 0; k < `SNN_NUM_INP; k++) begin
                    pot[k]  = 0;
                    pend[k] = 0;
                    pchg[k] = 0;
                    pper[k] = 0;
                    pph[k]  = 0;
                end
            end
            default: ;
        endcase
    endfunction

    // one transferred timestep: integrate, fire, then load the charges for the next one
    function automatic spike_vec_t model_step();
        spike_vec_t v;
        int         s;
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            s    = pot[i] + pend[i];
            v[i] = (s >= `SNN_THRESHOLD);
            pot[i] = v[i] ? 0 : ((s < POT_MIN) ? POT_MIN : s);
            if (pper[i] != 0 && pph[i] == pper[i] - 1) begin
                pend[i] = pchg[i];
                pph[i]  = 0;
            end else begin
                pend[i] = 0;
                if (pper[i] != 0) begin
                    pph[i]++;
                end
            end
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [79:0] exp, input logic [79:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    // called at a falling edge; returns at the falling edge after the command was taken
    task automatic send_cmd(input src_cmd_u cmd);
        src       = cmd;
        src_valid = 1'b1;
        while (!src_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        src_valid = 1'b0;
    endtask

    task automatic collect_run(input int r);
        int          len;
        int          got;
        logic [79:0] seen;
        len  = (row_cmd[r].run_view.len == '0) ? 1 : int'(row_cmd[r].run_view.len);
        got  = 0;
        seen = '0;
        // a NOP stays offered through the run, so it waits on src_ready while the run is busy
        src       = '0;
        src_valid = 1'b1;
        while (got < len) begin
            // a timestep held in the output register has already left the source
            check_val({row_name[r], " src_ready"}, (len - got - int'(out_valid)) <= 1, src_ready);
            out_ready = next_lfsr_bit() | next_lfsr_bit();
            if (out_valid && out_ready) begin
                check_val(row_name[r], model_step(), out_spikes);
                seen[4*got +: 4] = out_spikes;
                got++;
            end
            @(negedge clk);
        end
        src_valid = 1'b0;
        if (out_valid) begin
            $display("%s: a spike vector came after the last timestep of the run", row_name[r]);
            errors++;
        end
        check_val({row_name[r], " table"}, row_exp[r], seen);
    endtask

    initial begin
        int err_before;
        clk       = 1'b0;
        arstn     = 1'b0;
        src_valid = 1'b0;
        src       = '0;
        out_ready = 1'b1;
        lfsr      = 32'h921b;
        errors    = 0;
        failed    = 0;
        wd_cycles = 0;
        for (int i = 0; i < `SNN_NUM_INP; i++) begin
            pot[i]  = 0;
            pend[i] = 0;
            pchg[i] = 0;
            pper[i] = 0;
            pph[i]  = 0;
        end

        // expected vectors hold timestep 1 in the lowest nibble
        add_row("run_len0",     make_run(0), 'h0);
        add_row("run_len4",     make_run(4), 'h0);
        add_row("spk_70",       make_spk(SPK, 2, 70, 0), 'h0);
        add_row("run_spk_70",   make_run(3), 'h004);
        add_row("spk_40_a",     make_spk(SPK, 1, 40, 0), 'h0);
        add_row("run_40_a",     make_run(1), 'h0);
        add_row("spk_40_b",     make_spk(SPK, 1, 40, 0), 'h0);
        add_row("run_40_b",     make_run(1), 'h2);
        add_row("prd_p3",       make_spk(SPK_PRDC, 0, 64, 3), 'h0);
        add_row("run_prd_p3",   make_run(8), 'h01001001);
        add_row("prd_off",      make_spk(SPK_PRDC, 0, 64, 0), 'h0);
        add_row("run_prd_off",  make_run(4), 'h0001);
        add_row("prd_p2",       make_spk(SPK_PRDC, 3, 64, 2), 'h0);
        add_row("spk_50",       make_spk(SPK, 1, 50, 0), 'h0);
        add_row("run_pre_clr",  make_run(2), 'h08);
        add_row("clr",          make_spk(CLR, 0, 0, 0), 'h0);
        add_row("spk_30",       make_spk(SPK, 1, 30, 0), 'h0);
        add_row("run_post_clr", make_run(4), 'h0);
        add_row("prd_neg",      make_spk(SPK_PRDC, 2, -128, 1), 'h0);
        add_row("run_neg_sat",  make_run(17), 'h0);
        add_row("prd_pos",      make_spk(SPK_PRDC, 2, 127, 1), 'h0);
        add_row("run_pos",      make_run(18), 80'h44_0000_0000_0000_0000);

        for (int r = 0; r < row_cmd.size(); r++) begin
            if (row_cmd[r].run_view.opc == RUN) begin
                wd_cycles += (row_cmd[r].run_view.len == '0) ? 4 : 4 * row_cmd[r].run_view.len;
            end
        end
        wd_cycles += 100;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;

        for (int r = 0; r < row_cmd.size(); r++) begin
            err_before = errors;
            send_cmd(row_cmd[r]);
            model_cmd(row_cmd[r]);
            if (row_cmd[r].run_view.opc == RUN) begin
                collect_run(r);
            end
            if (errors == err_before) begin
                $display("test %s ok", row_name[r]);
            end else begin
                $display("test %s failed", row_name[r]);
                failed++;
            end
        end

        if (i_snn_core.i_snn_core_sva.sva_errors != 0) begin
            $display("%0d bound assertions failed during the run",
                     i_snn_core.i_snn_core_sva.sva_errors);
            errors += i_snn_core.i_snn_core_sva.sva_errors;
        end

        $display("tests %0d, failed %0d, errors %0d", row_cmd.size(), failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/net_pkg.sv
hdl/src_pkg.sv
hdl/network_source.sv
hdl/periodic_table.sv
hdl/lif_layer.sv
hdl/snn_core.sv
tb/snn_core_sva.sv
tb/snn_core_tb.sv

/* Bender.yml */
package:
  name: snn_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/net_pkg.sv
      - hdl/src_pkg.sv
      - hdl/network_source.sv
      - hdl/periodic_table.sv
      - hdl/lif_layer.sv
      - hdl/snn_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/snn_core_sva.sv
      - tb/snn_core_tb.sv
